// ==== verilog/udp_rec_pkg.sv ====
/* board addresses, protocol bytes, fifo sizing and the
   beat / status structs shared by the udp receive path */
package udp_rec_pkg;

  // **************************************************
  // board identity
  // **************************************************
  localparam logic [47:0] BOARD_MAC  = 48'ha0_b1_c2_d3_e1_e1;            // own mac
  localparam logic [31:0] BOARD_IP   = {8'd192, 8'd168, 8'd1, 8'd11};    // 192.168.1.11
  localparam logic [15:0] BOARD_PORT = 16'd1234;                          // udp dest port

  // protocol bytes
  localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;   // ethertype ipv4
  localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;      // ip protocol udp
  localparam logic [7:0]  ETH_PREAMBLE  = 8'h55;      // preamble byte
  localparam logic [7:0]  ETH_SFD       = 8'hd5;      // start of frame delimiter
  localparam logic [7:0]  IP_VER_IHL    = 8'h45;      // version 4, 20 byte header

  // fifo sizing
  localparam int FIFO_DEPTH_W = 1024;   // depth in 16-bit words
  localparam int LEVEL_W      = 11;     // level 0..1024

  // **************************************************
  // structs
  // **************************************************
  typedef struct packed {
    logic       dv;     // gmii data valid
    logic [7:0] data;   // gmii byte
  } gmii_rx_t;

  typedef struct packed {
    logic       en;     // one cycle per payload byte
    logic [7:0] data;   // payload byte
  } rec_beat_t;

  typedef struct packed {
    logic        pkt_done;   // one pulse per accepted frame
    logic [15:0] byte_num;   // udp length minus 8
  } rec_stat_t;

endpackage

// ==== verilog/udp_rx.sv ====
/* gmii frame parser: preamble strip, mac / ip / udp header filter,
   payload byte strobe and end of packet status */
`timescale 1ns/1ns

module udp_rx import udp_rec_pkg::*; (
  input  logic      gmii_rx_clk,
  input  logic      reset,
  input  gmii_rx_t  rx,          // registered gmii beat
  output rec_beat_t rec_beat,    // payload byte strobe
  output rec_stat_t rec_stat     // done pulse + payload length
);

  typedef enum logic [2:0] {
    s_idle,
    s_preamble,
    s_eth_hdr,
    s_ip_hdr,
    s_udp_hdr,
    s_payload,
    s_drop
  } state_t;

  state_t      state;
  logic [15:0] cnt;             // byte index inside current section
  logic        mac_board;       // dest mac matches board so far
  logic        mac_bcast;       // dest mac all ff so far
  logic        mac_board_nxt;
  logic        mac_bcast_nxt;
  logic        field_ok;        // current byte passes its field check
  logic        pay_last;        // last payload byte on rx
  logic        beat_en;
  logic [7:0]  beat_data;
  logic        done_pend;       // last byte strobed, done next cycle
  logic        pkt_done;
  logic [7:0]  len_hi;          // udp length high byte
  logic [15:0] byte_num;        // payload length

  assign pay_last = (cnt == byte_num - 16'd1);

  // **************************************************
  // per-byte field compare
  // **************************************************
  always_comb begin
    field_ok      = 1'b1;
    mac_board_nxt = mac_board;
    mac_bcast_nxt = mac_bcast;
    case (state)
      s_eth_hdr: begin
        if (cnt < 16'd6) begin   // dest mac, msb first
          mac_board_nxt = mac_board && (rx.data == BOARD_MAC[8*(5-cnt[2:0]) +: 8]);
          mac_bcast_nxt = mac_bcast && (rx.data == 8'hff);
          field_ok      = mac_board_nxt || mac_bcast_nxt;
        end else if (cnt == 16'd12) begin
          field_ok = (rx.data == ETH_TYPE_IPV4[15:8]);
        end else if (cnt == 16'd13) begin
          field_ok = (rx.data == ETH_TYPE_IPV4[7:0]);
        end
      end
      s_ip_hdr: begin
        case (cnt)
          16'd0:  field_ok = (rx.data == IP_VER_IHL);     // no options
          16'd9:  field_ok = (rx.data == IP_PROTO_UDP);
          16'd16, 16'd17, 16'd18, 16'd19: begin           // dest ip
            field_ok = (rx.data == BOARD_IP[8*(3-cnt[1:0]) +: 8]);
          end
          default: field_ok = 1'b1;                       // src ip, len, ttl ignored
        endcase
      end
      s_udp_hdr: begin
        if (cnt == 16'd2) begin
          field_ok = (rx.data == BOARD_PORT[15:8]);
        end else if (cnt == 16'd3) begin
          field_ok = (rx.data == BOARD_PORT[7:0]);
        end
      end
      default: field_ok = 1'b1;   // idle / preamble check their own bytes
    endcase
  end

  // **************************************************
  // state machine
  // **************************************************
  always_ff @(posedge gmii_rx_clk) begin
    if (reset) begin
      state     <= s_idle;
      cnt       <= '0;
      mac_board <= 1'b0;
      mac_bcast <= 1'b0;
      beat_en   <= 1'b0;
      done_pend <= 1'b0;
      pkt_done  <= 1'b0;
    end else begin
      beat_en   <= 1'b0;
      done_pend <= 1'b0;
      pkt_done  <= done_pend;        // one cycle after last strobe
      mac_board <= mac_board_nxt;
      mac_bcast <= mac_bcast_nxt;
      cnt       <= cnt + 16'd1;
      if (!rx.dv) begin              // frame end or gap, also truncation
        state <= s_idle;
        cnt   <= '0;
      end else if (!field_ok) begin
        state <= s_drop;             // wrong address or protocol
      end else begin
        case (state)
          s_idle: begin
            state <= (rx.data == ETH_PREAMBLE) ? s_preamble : s_drop;
            cnt   <= 16'd1;          // first 55 seen
          end
          s_preamble: begin
            if (rx.data == ETH_SFD && cnt == 16'd7) begin
              state     <= s_eth_hdr;
              cnt       <= '0;
              mac_board <= 1'b1;     // arm both mac matches
              mac_bcast <= 1'b1;
            end else if (rx.data != ETH_PREAMBLE || cnt == 16'd7) begin
              state <= s_drop;       // bad preamble length or byte
            end
          end
          s_eth_hdr: begin
            if (cnt == 16'd13) begin   // 14 byte mac header
              state <= s_ip_hdr;
              cnt   <= '0;
            end
          end
          s_ip_hdr: begin
            if (cnt == 16'd19) begin   // 20 byte ip header
              state <= s_udp_hdr;
              cnt   <= '0;
            end
          end
          s_udp_hdr: begin
            if (cnt == 16'd7) begin    // 8 byte udp header
              cnt <= '0;
              if (byte_num == 16'd0) begin
                state     <= s_drop;   // empty datagram, still report it
                done_pend <= 1'b1;
              end else begin
                state <= s_payload;
              end
            end
          end
          s_payload: begin
            beat_en <= 1'b1;
            if (pay_last) begin
              state     <= s_drop;     // skip padding and fcs
              done_pend <= 1'b1;
            end
          end
          default: state <= s_drop;    // wait for dv low
        endcase
      end
    end
  end

  // payload and length capture
  always_ff @(posedge gmii_rx_clk) begin
    beat_data <= rx.data;
    if (rx.dv && state == s_udp_hdr && cnt == 16'd4) begin
      len_hi <= rx.data;
    end
    if (rx.dv && state == s_udp_hdr && cnt == 16'd5) begin
      byte_num <= {len_hi, rx.data} - 16'd8;   // strip udp header
    end
  end

  assign rec_beat = '{en: beat_en, data: beat_data};
  assign rec_stat = '{pkt_done: pkt_done, byte_num: byte_num};

endmodule

// ==== verilog/rec_fifo.sv ====
/* byte to halfword packing fifo, first byte high,
   registered read and water level */
`timescale 1ns/1ns

module rec_fifo import udp_rec_pkg::*; (
  input  logic               gmii_rx_clk,
  input  logic               reset,
  input  rec_beat_t          wr,          // byte strobe from parser
  input  logic               flush,       // pkt_done, push odd byte
  input  logic               rd_en,
  output logic [15:0]        rd_data,
  output logic               rd_valid,
  output logic [LEVEL_W-1:0] rd_level
);

  logic [15:0]        mem [FIFO_DEPTH_W];   // word storage
  logic [LEVEL_W-1:0] wr_ptr;               // msb is wrap bit
  logic [LEVEL_W-1:0] rd_ptr;
  logic               hold_valid;           // high byte waiting for partner
  logic [7:0]         hold_byte;
  logic               word_wr;
  logic [15:0]        word_data;
  logic               full;
  logic               rd_go;

  assign rd_level = wr_ptr - rd_ptr;
  assign full     = (rd_level == LEVEL_W'(FIFO_DEPTH_W));
  assign rd_go    = rd_en && (rd_level != '0);

  // **************************************************
  // byte pairing
  // **************************************************
  always_comb begin
    word_wr   = 1'b0;
    word_data = {hold_byte, wr.data};       // second byte low
    if (wr.en && hold_valid) begin
      word_wr = 1'b1;
    end else if (!wr.en && flush && hold_valid) begin
      word_wr   = 1'b1;
      word_data = {hold_byte, 8'h00};       // odd tail, zero pad
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (reset) begin
      hold_valid <= 1'b0;
    end else if (wr.en) begin
      hold_valid <= !hold_valid;
    end else if (flush) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (wr.en && !hold_valid) begin
      hold_byte <= wr.data;                 // first byte of a pair
    end
  end

  // **************************************************
  // storage and pointers
  // **************************************************
  always_ff @(posedge gmii_rx_clk) begin
    if (word_wr && !full) begin
      mem[wr_ptr[LEVEL_W-2:0]] <= word_data;
    end
    if (rd_go) begin
      rd_data <= mem[rd_ptr[LEVEL_W-2:0]];
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rd_valid <= 1'b0;
    end else begin
      if (word_wr && !full) begin
        wr_ptr <= wr_ptr + 1'b1;   // full drops the word
      end
      if (rd_go) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      rd_valid <= rd_go;           // data lands with valid
    end
  end

endmodule

// ==== verilog/udp_rec_top.sv ====
/* udp receive top: gmii input register, parser,
   packing fifo and level driven auto read */
`timescale 1ns/1ns

module udp_rec_top import udp_rec_pkg::*; (
  input  logic        gmii_rx_clk,
  input  logic        reset,
  input  logic        gmii_rx_dv,
  input  logic [7:0]  gmii_rxd,
  output logic        rd_en,        // auto read strobe
  output logic        rd_valid,
  output logic [15:0] rd_data,
  output rec_stat_t   rec_stat
);

  gmii_rx_t           rx;          // registered gmii beat
  rec_beat_t          rec_beat;    // parser to fifo
  logic [LEVEL_W-1:0] rd_level;

  // input register, one cycle
  always_ff @(posedge gmii_rx_clk) begin
    if (reset) begin
      rx.dv <= 1'b0;
    end else begin
      rx.dv <= gmii_rx_dv;
    end
    rx.data <= gmii_rxd;
  end

  // read whenever a word is stored
  assign rd_en = (rd_level != '0);

  udp_rx u_udp_rx (
    .gmii_rx_clk (gmii_rx_clk),
    .reset       (reset),
    .rx          (rx),
    .rec_beat    (rec_beat),
    .rec_stat    (rec_stat)
  );

  rec_fifo u_rec_fifo (
    .gmii_rx_clk (gmii_rx_clk),
    .reset       (reset),
    .wr          (rec_beat),
    .flush       (rec_stat.pkt_done),   // push odd last byte
    .rd_en       (rd_en),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid),
    .rd_level    (rd_level)
  );

endmodule

// ==== tb/udp_rec_chk.sv ====
/* bound assertions on the udp receive top for read strobe timing,
   fifo level range, strobe exclusion and known read data */
`timescale 1ns/1ns

module udp_rec_chk import udp_rec_pkg::*; (
  input logic               gmii_rx_clk,
  input logic               reset,
  input logic               rd_en,
  input logic               rd_valid,
  input logic [15:0]        rd_data,
  input logic [LEVEL_W-1:0] rd_level,
  input rec_beat_t          rec_beat,
  input rec_stat_t          rec_stat
);

  // registered read puts valid one cycle behind the strobe
  a_valid_follows: assert property (@(posedge gmii_rx_clk) disable iff (reset)
    rd_valid == $past(rd_en))
    else $error("rd_valid does not follow rd_en by one cycle");

  // a read past empty wraps the level above the depth
  a_no_empty_read: assert property (@(posedge gmii_rx_clk) disable iff (reset)
    rd_level <= LEVEL_W'(FIFO_DEPTH_W))
    else $error("fifo level out of range, read past empty or write past full");

  // last strobe and done pulse never overlap
  a_beat_done_excl: assert property (@(posedge gmii_rx_clk) disable iff (reset)
    !(rec_beat.en && rec_stat.pkt_done))
    else $error("payload strobe and pkt_done in the same cycle");

  a_data_known: assert property (@(posedge gmii_rx_clk) disable iff (reset)
    rd_valid |-> !$isunknown(rd_data))
    else $error("unknown rd_data while rd_valid");

endmodule

bind udp_rec_top udp_rec_chk u_chk (
  .gmii_rx_clk (gmii_rx_clk),
  .reset       (reset),
  .rd_en       (rd_en),
  .rd_valid    (rd_valid),
  .rd_data     (rd_data),
  .rd_level    (rd_level),
  .rec_beat    (rec_beat),
  .rec_stat    (rec_stat)
);

// ==== tb/udp_rec_tb.sv ====
/* testbench for the udp receive top: clock, reset, frame builder
   from the test table, word and length scoreboard */
`timescale 1ns/1ns

module udp_rec_tb import udp_rec_pkg::*; ();

  localparam int DRAIN_LIMIT = 4000;          // cycles to empty the fifo
  localparam int MAX_TESTS   = 16;

  logic        gmii_rx_clk;
  logic        reset;
  logic        gmii_rx_dv;
  logic [7:0]  gmii_rxd;
  logic        rd_en;
  logic        rd_valid;
  logic [15:0] rd_data;
  rec_stat_t   rec_stat;

  logic [15:0] test_mem [0:7*MAX_TESTS-1];    // 7 columns per test
  logic [31:0] lfsr;
  logic [7:0]  frame_q [$];                   // bytes of the frame being built
  logic [15:0] exp_words [$];
  logic [15:0] exp_lens [$];
  logic [15:0] exp_item;
  int          accept_count;
  int          done_count;
  int          test_idx;
  int          wait_cnt;

  udp_rec_top UUT (
    .gmii_rx_clk (gmii_rx_clk),
    .reset       (reset),
    .gmii_rx_dv  (gmii_rx_dv),
    .gmii_rxd    (gmii_rxd),
    .rd_en       (rd_en),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .rec_stat    (rec_stat)
  );

  initial begin
    gmii_rx_clk = 1'b0;
    forever #4 gmii_rx_clk = ~gmii_rx_clk;    // 8 ns period
  end

  // **************************************************
  // helpers
  // **************************************************
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("Error: %s got %h expected %h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois, right shift
  endfunction

  task automatic take_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]};   // one bit per step
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic push_bytes(input logic [47:0] val, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      frame_q.push_back(val[8*i +: 8]);       // msb first on the wire
    end
  endtask

  // **************************************************
  // one frame from one table row
  // **************************************************
  task automatic run_test(input int t);
    logic [15:0] len;
    logic [47:0] dst_mac;
    logic [31:0] dst_ip;
    logic [7:0]  pay [$];
    logic [7:0]  b;
    logic [7:0]  lo;
    len     = test_mem[7*t+5];
    dst_mac = (test_mem[7*t] == 16'd0) ? BOARD_MAC :
              (test_mem[7*t] == 16'd1) ? 48'hffff_ffff_ffff : 48'h0200_0000_0001;
    dst_ip  = (test_mem[7*t+1] == 16'd0) ? BOARD_IP : 32'hc0a8_0163;
    frame_q = {};
    push_bytes(48'h5555_5555_5555, 6);
    push_bytes({8'h55, 8'hd5}, 2);            // last preamble byte, sfd
    push_bytes(dst_mac, 6);
    push_bytes(48'h000a_3501_fec0, 6);        // source mac
    push_bytes(test_mem[7*t+2], 2);           // ethertype
    push_bytes({16'h4500, len + 16'd28}, 4);  // ver/ihl, tos, total length
    push_bytes({16'h0000, 16'h4000}, 4);      // id, flags
    push_bytes({8'h40, test_mem[7*t+3][7:0], 16'h0000}, 4);   // ttl, proto, csum
    push_bytes(32'hc0a8_0102, 4);             // source ip
    push_bytes(dst_ip, 4);
    push_bytes({16'h1f90, test_mem[7*t+4]}, 4);   // ports
    push_bytes({len + 16'd8, 16'h0000}, 4);   // udp length, csum
    for (int j = 0; j < int'(len); j++) begin
      take_byte(b);
      frame_q.push_back(b);
      pay.push_back(b);
    end
    push_bytes(32'hdead_beef, 4);             // dummy fcs
    if (test_mem[7*t+6] != 16'd0) begin
      for (int j = 0; j < int'(len); j += 2) begin
        lo = (j + 1 < int'(len)) ? pay[j+1] : 8'h00;   // odd tail zero padded
        exp_words.push_back({pay[j], lo});
      end
      exp_lens.push_back(len);
      accept_count++;
    end
    foreach (frame_q[k]) begin
      @(negedge gmii_rx_clk);
      gmii_rx_dv = 1'b1;
      gmii_rxd   = frame_q[k];
    end
    repeat (12) begin                         // inter frame gap
      @(negedge gmii_rx_clk);
      gmii_rx_dv = 1'b0;
      gmii_rxd   = 8'h00;
    end
  endtask

  // scoreboard, outputs are stable at the falling edge
  always @(negedge gmii_rx_clk) begin
    if (!reset) begin
      if (rd_valid) begin
        if (exp_words.size() == 0) begin
          fail_run("rd_valid seen with no word expected");
        end else begin
          exp_item = exp_words.pop_front();
          check_value("rd_data", rd_data, exp_item);
        end
      end
      if (rec_stat.pkt_done) begin
        done_count++;
        if (exp_lens.size() == 0) begin
          fail_run("pkt_done seen for a frame that should be rejected");
        end else begin
          exp_item = exp_lens.pop_front();
          check_value("rec_stat.byte_num", rec_stat.byte_num, exp_item);
        end
      end
    end
  end

  // **************************************************
  // main sequence
  // **************************************************
  initial begin
    reset        = 1'b1;
    gmii_rx_dv   = 1'b0;
    gmii_rxd     = 8'h00;
    lfsr         = 32'h10de_3bb5;
    accept_count = 0;
    done_count   = 0;
    test_idx     = 0;
    foreach (test_mem[i]) test_mem[i] = 16'hffff;   // end marker
    $readmemh("tb/udp_rec_tests.txt", test_mem);
    repeat (10) @(posedge gmii_rx_clk);
    @(negedge gmii_rx_clk);
    reset = 1'b0;
    @(negedge gmii_rx_clk);
    check_value("rd_en", rd_en, 1'b0);
    check_value("rd_valid", rd_valid, 1'b0);
    while (test_idx < MAX_TESTS && test_mem[7*test_idx] != 16'hffff) begin
      run_test(test_idx);
      test_idx++;
    end
    wait_cnt = 0;
    while ((exp_words.size() != 0 || exp_lens.size() != 0) && wait_cnt < DRAIN_LIMIT) begin
      @(negedge gmii_rx_clk);
      wait_cnt++;
    end
    if (exp_words.size() != 0 || exp_lens.size() != 0) begin
      fail_run("timeout waiting for expected words and packets");
    end
    repeat (2) @(negedge gmii_rx_clk);
    check_value("rd_en", rd_en, 1'b0);
    check_value("rd_valid", rd_valid, 1'b0);
    if (test_idx == 0 || done_count != accept_count) begin
      fail_run("no tests read or wrong number of pkt_done pulses");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// ==== udp_rec.f ====
verilog/udp_rec_pkg.sv
verilog/udp_rx.sv
verilog/rec_fifo.sv
verilog/udp_rec_top.sv
tb/udp_rec_chk.sv
tb/udp_rec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the udp receive testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
  --top-module udp_rec_tb -Mdir obj_dir -f udp_rec.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vudp_rec_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
  exit 0
fi
exit 1

// ==== tb/udp_rec_tests.txt ====
// mac_sel ip_sel ethertype proto port payload_len accept  (hex)
// mac_sel 0 board 1 broadcast 2 other, ip_sel 0 board 1 other
0 0 0800 11 04d2 0010 1
1 0 0800 11 04d2 0007 1
2 0 0800 11 04d2 0010 0
0 1 0800 11 04d2 0010 0
0 0 0806 11 04d2 0010 0
0 0 0800 06 04d2 0010 0
0 0 0800 11 04d3 0010 0
0 0 0800 11 04d2 0021 1
0 0 0800 11 04d2 0001 1
